// File: flist.f
+incdir+hw
hw/sys86_pkg.sv
hw/video_if.sv
hw/video_timing.sv
hw/pixel_mixer.sv
hw/palette_lookup.sv
hw/system86_video.sv
verif/video_checker.sv
verif/tb_system86.sv

// File: Bender.yml
package:
  name: system86_video

sources:
  - include_dirs:
      - hw
    files:
      - hw/sys86_pkg.sv
      - hw/video_if.sv
      - hw/video_timing.sv
      - hw/pixel_mixer.sv
      - hw/palette_lookup.sv
      - hw/system86_video.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/video_checker.sv
      - verif/tb_system86.sv

// File: verif/tb_system86.sv
`timescale 1ns/1ps
`default_nettype none

`include "sys86_cfg.svh"

module tb_system86 import sys86_pkg::*; ();

	// Two frames of dots plus margin, 100 ns a cycle
	localparam longint WATCHDOG_NS =
		(longint'(`PIX_DIV) * `H_TOTAL * `V_TOTAL * 2 + 1000) * 100;

	logic clk_48m;
	logic reset;
	dot_t dot;
	logic bank;
	logic backcolor_we;
	dot_t md;
	logic pal_we;
	clut_addr_t pal_addr;
	rgb_t pal_data;
	logic clk_6m_en;
	pos_t hpos;
	pos_t vpos;
	gun_t red, green, blue;
	logic sync, hsync_n, vsync_n, hblank_n, vblank_n;

	// Copies of what the DUT holds, read by the checker
	rgb_t pal_shadow [`PAL_DEPTH];
	dot_t back_shadow;
	int n_ok;
	int n_bad;

	system86_video u_dut (.*);
	video_checker u_chk (.*);

	initial begin
		clk_48m = 1'b0;
		forever #50 clk_48m = ~clk_48m;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Run timed out after %0d ns before the last test ended", WATCHDOG_NS);
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// Returns 5 ns into a cycle where clk_6m_en is high
	task automatic wait_pix_window();
		do begin
			@(posedge clk_48m);
			#5;
		end while (!clk_6m_en);
	endtask

	// About one dot in four forced see-through
	task automatic random_dot();
		dot = dot_t'($urandom);
		if ($urandom % 4 == 0)
			dot[3:0] = `TRANSPARENT_PEN;
		bank = 1'($urandom);
	endtask

	// Shadow moves now, the RAM takes it at the next edge
	task automatic write_palette(clut_addr_t a, rgb_t data);
		pal_we = 1'b1;
		pal_addr = a;
		pal_data = data;
		pal_shadow[a] = data;
	endtask

	task automatic write_backcolor(dot_t c);
		backcolor_we = 1'b1;
		md = c;
	endtask

	// One-cycle strobes; the back colour counts only after its edge
	task automatic release_strobes();
		@(posedge clk_48m);
		#5;
		if (backcolor_we)
			back_shadow = md;
		backcolor_we = 1'b0;
		pal_we = 1'b0;
	endtask

	task automatic end_test(string name, int base);
		if (u_chk.errors == base) begin
			n_ok++;
			$display("test %s: ok", name);
		end else begin
			n_bad++;
			$display("test %s: %0d mismatches", name, u_chk.errors - base);
		end
	endtask

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		int base;
		logic done;
		dot_t d;
		logic b;
		reset = 1'b1;
		dot = '0;
		bank = 1'b0;
		backcolor_we = 1'b0;
		md = '0;
		pal_we = 1'b0;
		pal_addr = '0;
		pal_data = '0;
		back_shadow = '0;
		foreach (pal_shadow[i])
			pal_shadow[i] = '0;
		void'($urandom(32'h673));

		// Reset held for three cycles, checked inside and after
		base = u_chk.errors;
		repeat (2) @(posedge clk_48m);
		#5;
		u_chk.check_reset_state();
		@(posedge clk_48m);
		#5;
		reset = 1'b0;
		@(posedge clk_48m);
		#5;
		u_chk.check_reset_state();
		end_test("reset_state", base);

		// One palette write per dot while the raster runs
		base = u_chk.errors;
		for (int i = 0; i < `PAL_DEPTH; i++) begin
			wait_pix_window();
			random_dot();
			write_palette(clut_addr_t'(i), rgb_t'($urandom));
			if (i == 0)
				write_backcolor(dot_t'($urandom));
			release_strobes();
		end
		end_test("palette_load", base);

		// Rest of the frame, new back colour halfway down
		base = u_chk.errors;
		done = 1'b0;
		while (!done) begin
			wait_pix_window();
			random_dot();
			if (vpos == pos_t'(`V_ACTIVE / 2) && hpos == '0)
				write_backcolor(dot_t'($urandom));
			done = (vpos == pos_t'(`V_TOTAL - 1)) && (hpos == pos_t'(`H_TOTAL - 1));
			release_strobes();
		end
		end_test("full_frame", base);

		// Rewrites inside the picture, three dots on one address
		base = u_chk.errors;
		do begin
			wait_pix_window();
			random_dot();
			release_strobes();
		end while (vpos != pos_t'(16) || hpos != pos_t'(32));
		for (int r = 0; r < 8; r++) begin
			d = dot_t'($urandom);
			if (d[3:0] == `TRANSPARENT_PEN)
				d[3:0] = 4'h0;
			b = 1'($urandom);
			for (int k = 0; k < 3; k++) begin
				wait_pix_window();
				dot = d;
				bank = b;
				if (k == 1)
					write_palette({b, d}, ~pal_shadow[{b, d}]);
				release_strobes();
			end
		end
		// Drain the two stages
		repeat (3) begin
			wait_pix_window();
			release_strobes();
		end
		end_test("palette_rewrite", base);

		if (u_chk.pixels == 0) begin
			$display("No dot ever reached the colour outputs");
			n_bad++;
		end
		$display("Summary: %0d tests ok, %0d tests with errors, %0d dots compared",
			n_ok, n_bad, u_chk.pixels);
		if (n_bad == 0 && u_chk.errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/video_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "sys86_cfg.svh"

module video_checker import sys86_pkg::*; (
	input logic clk_48m,
	input logic reset,
	input dot_t dot,
	input logic bank,
	input logic clk_6m_en,
	input pos_t hpos,
	input pos_t vpos,
	input gun_t red,
	input gun_t green,
	input gun_t blue,
	input logic sync,
	input logic hsync_n,
	input logic vsync_n,
	input logic hblank_n,
	input logic vblank_n
);

	// What the monitor side should show for one dot
	typedef struct packed {
		rgb_t rgb;
		logic hblank;
		logic vblank;
		logic hsync_n;
		logic vsync_n;
	} expect_t;

	// Two dots in flight between sampling and the guns
	expect_t pipe [$];
	expect_t exp_px;
	pos_t exp_h;
	pos_t exp_v;
	int unsigned gap;
	int errors;
	int pixels;

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic expect_t ref_pixel(pos_t h, pos_t v, dot_t d, logic b, dot_t back,
		input rgb_t pal [`PAL_DEPTH]);
		expect_t e;
		dot_t idx;
		e.hblank = (h >= `H_ACTIVE);
		e.vblank = (v >= `V_ACTIVE);
		e.hsync_n = !(h >= `H_SYNC_START && h < `H_SYNC_START + `H_SYNC_LEN);
		e.vsync_n = !(v >= `V_SYNC_START && v < `V_SYNC_START + `V_SYNC_LEN);
		// See-through pen falls back to the back colour
		idx = (d[3:0] == `TRANSPARENT_PEN) ? back : d;
		e.rgb = (e.hblank || e.vblank) ? rgb_t'(0) : pal[{b, idx}];
		return e;
	endfunction

	task automatic compare(string name, int unsigned expected, int unsigned actual);
		if (expected != actual) begin
			errors++;
			$display("FAIL %s expected 0x%0h actual 0x%0h at %0t ns",
				name, expected, actual, $time);
		end
	endtask

	// Values held while reset is high and just after
	task automatic check_reset_state();
		compare("red", 0, red);
		compare("green", 0, green);
		compare("blue", 0, blue);
		compare("sync", 1, sync);
		compare("hsync_n", 1, hsync_n);
		compare("vsync_n", 1, vsync_n);
		compare("hblank_n", 1, hblank_n);
		compare("vblank_n", 1, vblank_n);
		compare("hpos", 0, hpos);
		compare("vpos", 0, vpos);
		compare("clk_6m_en", 0, clk_6m_en);
	endtask

	////////////////////////////////////////
	// Per-dot compare
	////////////////////////////////////////

	// Outputs read here still hold the values from before this edge
	always @(posedge clk_48m) begin
		if (reset) begin
			pipe.delete();
			exp_h = '0;
			exp_v = '0;
			gap = 0;
		end else if (!clk_6m_en) begin
			gap++;
		end else begin
			compare("clk_6m_en period", `PIX_DIV, gap);
			compare("hpos", exp_h, hpos);
			compare("vpos", exp_v, vpos);
			if (pipe.size() == 2) begin
				exp_px = pipe.pop_front();
				pixels++;
				compare("red", exp_px.rgb[11:8], red);
				compare("green", exp_px.rgb[7:4], green);
				compare("blue", exp_px.rgb[3:0], blue);
				compare("hblank_n", !exp_px.hblank, hblank_n);
				compare("vblank_n", !exp_px.vblank, vblank_n);
				compare("hsync_n", exp_px.hsync_n, hsync_n);
				compare("vsync_n", exp_px.vsync_n, vsync_n);
				compare("sync", exp_px.hsync_n & exp_px.vsync_n, sync);
			end
			pipe.push_back(ref_pixel(exp_h, exp_v, dot, bank,
				tb_system86.back_shadow, tb_system86.pal_shadow));
			gap = 1;
			// Beam steps right, then down at the line end
			if (exp_h == pos_t'(`H_TOTAL - 1)) begin
				exp_h = '0;
				exp_v = (exp_v == pos_t'(`V_TOTAL - 1)) ? pos_t'(0) : exp_v + 1'b1;
			end else begin
				exp_h = exp_h + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hw/system86_video.sv
`timescale 1ns/1ps
`default_nettype none

module system86_video import sys86_pkg::*; (
	input  logic clk_48m,
	input  logic reset,

	// Tile and sprite generator
	input  dot_t dot,
	input  logic bank,

	// CPU writes
	input  logic backcolor_we,
	input  dot_t md,
	input  logic pal_we,
	input  clut_addr_t pal_addr,
	input  rgb_t pal_data,

	// Beam for the generator
	output logic clk_6m_en,
	output pos_t hpos,
	output pos_t vpos,

	// Monitor side
	output gun_t red,
	output gun_t green,
	output gun_t blue,
	output logic sync,
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank_n,
	output logic vblank_n
);

	beam_if beam ();
	color_if mix ();

	logic hblank;
	logic vblank;

	////////////////////////////////////////
	// Stage pipeline
	////////////////////////////////////////

	video_timing u_timing (
		.clk_48m (clk_48m),
		.reset   (reset),
		.hpos    (hpos),
		.vpos    (vpos),
		.beam    (beam)
	);

	pixel_mixer u_mixer (
		.clk_48m      (clk_48m),
		.reset        (reset),
		.beam         (beam),
		.dot          (dot),
		.bank         (bank),
		.backcolor_we (backcolor_we),
		.md           (md),
		.mix          (mix)
	);

	palette_lookup u_palette (
		.clk_48m  (clk_48m),
		.reset    (reset),
		.mix      (mix),
		.pal_we   (pal_we),
		.pal_addr (pal_addr),
		.pal_data (pal_data),
		.red      (red),
		.green    (green),
		.blue     (blue),
		.hsync_n  (hsync_n),
		.vsync_n  (vsync_n),
		.hblank   (hblank),
		.vblank   (vblank)
	);

	// Dot clock out so the generator can step
	assign clk_6m_en = beam.pix_en;

	// Composite sync low on either sync
	assign sync = hsync_n & vsync_n;
	assign hblank_n = ~hblank;
	assign vblank_n = ~vblank;

endmodule

`default_nettype wire

// File: hw/palette_lookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "sys86_cfg.svh"

module palette_lookup import sys86_pkg::*; (
	input  logic clk_48m,
	input  logic reset,
	color_if.sink mix,
	input  logic pal_we,
	input  clut_addr_t pal_addr,
	input  rgb_t pal_data,
	output gun_t red,
	output gun_t green,
	output gun_t blue,
	output logic hsync_n,
	output logic vsync_n,
	output logic hblank,
	output logic vblank
);

	rgb_t pal_ram [`PAL_DEPTH];
	rgb_t rd_word;

	////////////////////////////////////////
	// Colour table
	////////////////////////////////////////

	// Table starts out black
	initial begin
		for (int i = 0; i < `PAL_DEPTH; i++)
			pal_ram[i] = '0;
	end

	// Write port for loading and rewrites
	always_ff @(posedge clk_48m) begin
		if (pal_we)
			pal_ram[pal_addr] <= pal_data;
	end

	assign rd_word = pal_ram[mix.clut_addr];

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	// Syncs and blanks ride along with the colour
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			red <= '0;
			green <= '0;
			blue <= '0;
			hsync_n <= 1'b1;
			vsync_n <= 1'b1;
			hblank <= 1'b0;
			vblank <= 1'b0;
		end else if (mix.pix_en) begin
			if (mix.hblank || mix.vblank) begin
				// Guns dark outside the picture
				red <= '0;
				green <= '0;
				blue <= '0;
			end else begin
				red <= rd_word[11:8];
				green <= rd_word[7:4];
				blue <= rd_word[3:0];
			end
			hsync_n <= mix.hsync_n;
			vsync_n <= mix.vsync_n;
			hblank <= mix.hblank;
			vblank <= mix.vblank;
		end
	end

	// Visible dots carry a known colour
	a_rgb_known: assert property (@(posedge clk_48m) disable iff (reset)
		!(hblank || vblank) |-> !$isunknown({red, green, blue}));

endmodule

`default_nettype wire

// File: hw/pixel_mixer.sv
`timescale 1ns/1ps
`default_nettype none

`include "sys86_cfg.svh"

module pixel_mixer import sys86_pkg::*; (
	input  logic clk_48m,
	input  logic reset,
	beam_if.sink beam,
	input  dot_t dot,
	input  logic bank,
	input  logic backcolor_we,
	input  dot_t md,
	color_if.source mix
);

	dot_t backcolor;
	dot_t dot_sel;
	logic blank_in;

	////////////////////////////////////////
	// Back colour latch
	////////////////////////////////////////

	// CPU write from the master data bus
	always_ff @(posedge clk_48m) begin
		if (reset)
			backcolor <= '0;
		else if (backcolor_we)
			backcolor <= md;
	end

	////////////////////////////////////////
	// Dot selection
	////////////////////////////////////////

	// See-through pen shows the back colour
	always_comb begin
		if (dot[3:0] == `TRANSPARENT_PEN)
			dot_sel = backcolor;
		else
			dot_sel = dot;
	end

	assign blank_in = beam.hblank | beam.vblank;

	// Palette stage steps with the same dot clock
	assign mix.pix_en = beam.pix_en;

	////////////////////////////////////////
	// Mixer register
	////////////////////////////////////////

	always_ff @(posedge clk_48m) begin
		if (reset) begin
			mix.clut_addr <= '0;
			mix.hblank <= 1'b0;
			mix.vblank <= 1'b0;
			mix.hsync_n <= 1'b1;
			mix.vsync_n <= 1'b1;
		end else if (beam.pix_en) begin
			// Bank bit on top, blanked dots point at entry zero
			mix.clut_addr <= blank_in ? '0 : {bank, dot_sel};
			mix.hblank <= beam.hblank;
			mix.vblank <= beam.vblank;
			mix.hsync_n <= beam.hsync_n;
			mix.vsync_n <= beam.vsync_n;
		end
	end

	// Blanked dots never address the colour table
	a_blank_addr: assert property (@(posedge clk_48m) disable iff (reset)
		(mix.hblank || mix.vblank) |-> (mix.clut_addr == '0));

endmodule

`default_nettype wire

// File: hw/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "sys86_cfg.svh"

module video_timing import sys86_pkg::*; (
	input  logic clk_48m,
	input  logic reset,
	output pos_t hpos,
	output pos_t vpos,
	beam_if.source beam
);

	// Divider width for the dot clock
	localparam int unsigned DIV_W = $clog2(`PIX_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`PIX_DIV - 1);

	// Raster limits as beam positions
	localparam pos_t H_LAST = pos_t'(`H_TOTAL - 1);
	localparam pos_t V_LAST = pos_t'(`V_TOTAL - 1);
	localparam pos_t H_ACT = pos_t'(`H_ACTIVE);
	localparam pos_t V_ACT = pos_t'(`V_ACTIVE);
	localparam pos_t HS_LO = pos_t'(`H_SYNC_START);
	localparam pos_t HS_HI = pos_t'(`H_SYNC_START + `H_SYNC_LEN);
	localparam pos_t VS_LO = pos_t'(`V_SYNC_START);
	localparam pos_t VS_HI = pos_t'(`V_SYNC_START + `V_SYNC_LEN);

	logic [DIV_W-1:0] div_cnt;
	pos_t h_next;
	pos_t v_next;

	// Position inside a half-open window
	function automatic logic in_span(pos_t p, pos_t lo, pos_t hi);
		return (p >= lo) && (p < hi);
	endfunction

	////////////////////////////////////////
	// 6 MHz dot enable
	////////////////////////////////////////

	// Pulse lands on the cycle after the divider's last count
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			div_cnt <= '0;
			beam.pix_en <= 1'b0;
		end else begin
			if (div_cnt == DIV_LAST)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
			beam.pix_en <= (div_cnt == DIV_LAST);
		end
	end

	////////////////////////////////////////
	// Beam counters
	////////////////////////////////////////

	// Position after the coming dot step
	always_comb begin
		h_next = hpos + 1'b1;
		v_next = vpos;
		if (hpos == H_LAST) begin
			h_next = '0;
			// Line wrap moves the beam down
			if (vpos == V_LAST)
				v_next = '0;
			else
				v_next = vpos + 1'b1;
		end
	end

	// Levels are compared on the next position
	// so they line up with hpos and vpos once registered
	always_ff @(posedge clk_48m) begin
		if (reset) begin
			hpos <= '0;
			vpos <= '0;
			// Top-left dot is visible and outside both syncs
			beam.hblank <= 1'b0;
			beam.vblank <= 1'b0;
			beam.hsync_n <= 1'b1;
			beam.vsync_n <= 1'b1;
		end else if (beam.pix_en) begin
			hpos <= h_next;
			vpos <= v_next;
			beam.hblank <= (h_next >= H_ACT);
			beam.vblank <= (v_next >= V_ACT);
			beam.hsync_n <= !in_span(h_next, HS_LO, HS_HI);
			beam.vsync_n <= !in_span(v_next, VS_LO, VS_HI);
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Counter never runs past the line end
	a_hpos_range: assert property (@(posedge clk_48m) disable iff (reset)
		hpos < pos_t'(`H_TOTAL));

	// Dot enable is a single-cycle pulse
	a_pix_en_pulse: assert property (@(posedge clk_48m) disable iff (reset)
		beam.pix_en |=> !beam.pix_en);

endmodule

`default_nettype wire

// File: hw/video_if.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////
// Timing to mixer
////////////////////////////////////////

interface beam_if;

	// One clk_48m cycle per dot
	logic pix_en;

	// Blanking, active high
	logic hblank;
	logic vblank;

	// Syncs, active low
	logic hsync_n;
	logic vsync_n;

	modport source (
		output pix_en,
		output hblank,
		output vblank,
		output hsync_n,
		output vsync_n
	);

	modport sink (
		input pix_en,
		input hblank,
		input vblank,
		input hsync_n,
		input vsync_n
	);

endinterface

////////////////////////////////////////
// Mixer to palette
////////////////////////////////////////

interface color_if import sys86_pkg::*; ();

	logic pix_en;

	// Bank bit and chosen index, zero on blanked dots
	clut_addr_t clut_addr;

	// Blank bits kept apart for the board outputs
	logic hblank;
	logic vblank;

	logic hsync_n;
	logic vsync_n;

	modport source (
		output pix_en,
		output clut_addr,
		output hblank,
		output vblank,
		output hsync_n,
		output vsync_n
	);

	modport sink (
		input pix_en,
		input clut_addr,
		input hblank,
		input vblank,
		input hsync_n,
		input vsync_n
	);

endinterface

`default_nettype wire

// File: hw/sys86_pkg.sv
`default_nettype none

`include "sys86_cfg.svh"

package sys86_pkg;

	////////////////////////////////////////
	// Beam and dot types
	////////////////////////////////////////

	// Horizontal or vertical beam position
	typedef logic [8:0] pos_t;

	// Colour index, from tile generator or back colour latch
	typedef logic [7:0] dot_t;

	////////////////////////////////////////
	// Colour table types
	////////////////////////////////////////

	// Bank bit above a dot index
	typedef logic [$clog2(`PAL_DEPTH)-1:0] clut_addr_t;

	// One 4-bit gun
	typedef logic [3:0] gun_t;

	// Palette word, red in the top nibble, blue at the bottom
	typedef logic [11:0] rgb_t;

endpackage

`default_nettype wire

// File: hw/sys86_cfg.svh
`ifndef SYS86_CFG_SVH
`define SYS86_CFG_SVH

////////////////////////////////////////
// Clocking
////////////////////////////////////////

// clk_48m cycles per 6 MHz dot
`define PIX_DIV 8

////////////////////////////////////////
// Raster geometry, in pixels and lines
////////////////////////////////////////

`define H_TOTAL 384
`define H_ACTIVE 288
`define H_SYNC_START 304
`define H_SYNC_LEN 32

`define V_TOTAL 264
`define V_ACTIVE 224
`define V_SYNC_START 240
`define V_SYNC_LEN 8

////////////////////////////////////////
// Colour table
////////////////////////////////////////

// Two banks of 256 entries
`define PAL_DEPTH 512

// Low nibble of a see-through dot
`define TRANSPARENT_PEN 4'hF

`endif
